/* logic/lsu_agu.sv */
// ------------------
// address generation unit
// effective address, byte enables,
// alignment and range checks
// ------------------

module lsu_agu (
  input  lsu_pkg::lsu_op_e             lsu_op_i,
  input  logic [lsu_pkg::XLen-1:0]     operand_a_i,
  input  logic [lsu_pkg::XLen-1:0]     imm_i,
  output logic [lsu_pkg::XLen-1:0]     addr_o,
  output logic [lsu_pkg::BeW-1:0]      be_o,
  output logic                         is_store_o,
  output logic                         ex_valid_o,
  output lsu_pkg::ex_cause_e           ex_cause_o
);

  import lsu_pkg::*;

  logic [XLen-1:0] addr;
  logic [BeW-1:0]  base_be;
  logic            is_half;
  logic            is_word;
  logic            misaligned;
  logic            out_of_range;

  // base plus sign-extended immediate
  assign addr   = operand_a_i + imm_i;
  assign addr_o = addr;

  // ------------------
  // size decode
  // ------------------
  always_comb begin
    base_be    = 4'b0001;
    is_half    = 1'b0;
    is_word    = 1'b0;
    is_store_o = 1'b0;
    case (lsu_op_i)
      LB, LBU: begin
        base_be = 4'b0001;
      end
      LH, LHU: begin
        base_be = 4'b0011;
        is_half = 1'b1;
      end
      LW: begin
        base_be = 4'b1111;
        is_word = 1'b1;
      end
      SB: begin
        base_be    = 4'b0001;
        is_store_o = 1'b1;
      end
      SH: begin
        base_be    = 4'b0011;
        is_half    = 1'b1;
        is_store_o = 1'b1;
      end
      SW: begin
        base_be    = 4'b1111;
        is_word    = 1'b1;
        is_store_o = 1'b1;
      end
      default: begin
        base_be = 4'b0001;
      end
    endcase
  end

  // enables move up with the byte offset
  assign be_o = base_be << addr[1:0];

  // ------------------
  // exception checks
  // ------------------
  assign misaligned   = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));
  assign out_of_range = |addr[XLen-1:ByteAddrW];
  assign ex_valid_o   = misaligned || out_of_range;

  // access fault wins over misalignment
  always_comb begin
    if (out_of_range) begin
      ex_cause_o = is_store_o ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else begin
      ex_cause_o = is_store_o ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
    end
  end

endmodule

/* logic/lsu_data_ram.sv */
// ------------------
// tightly coupled data RAM
// single port, byte write enables,
// registered read data
// ------------------

module lsu_data_ram (
  input  logic                          clk_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [lsu_pkg::RamAddrW-1:0]  addr_i,
  input  logic [lsu_pkg::BeW-1:0]       be_i,
  input  logic [lsu_pkg::XLen-1:0]      wdata_i,
  output logic [lsu_pkg::XLen-1:0]      rdata_o
);

  import lsu_pkg::*;

  logic [XLen-1:0] mem [RamWords];
  logic [XLen-1:0] rdata_q;

  // write at the edge, read data one cycle later
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < BeW; i++) begin
          if (be_i[i]) begin
            mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* logic/lsu_load_unit.sv */
// ------------------
// load path
// RAM read request, data extraction,
// sign extension, registered response
// ------------------

module lsu_load_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          valid_i,
  input  lsu_pkg::lsu_op_e              lsu_op_i,
  input  logic [lsu_pkg::XLen-1:0]      addr_i,
  input  logic [lsu_pkg::TransIdW-1:0]  trans_id_i,
  input  logic                          ex_valid_i,
  input  lsu_pkg::ex_cause_e            ex_cause_i,
  input  logic [lsu_pkg::XLen-1:0]      ram_rdata_i,
  output logic                          ram_re_o,
  output logic                          load_valid_o,
  output logic [lsu_pkg::TransIdW-1:0]  load_trans_id_o,
  output logic [lsu_pkg::XLen-1:0]      load_result_o,
  output logic                          load_ex_valid_o,
  output lsu_pkg::ex_cause_e            load_ex_cause_o,
  output logic [lsu_pkg::XLen-1:0]      load_ex_tval_o
);

  import lsu_pkg::*;

  logic                valid_q;
  logic                ex_valid_q;
  lsu_op_e             op_q;
  logic [XLen-1:0]     addr_q;
  logic [TransIdW-1:0] trans_id_q;
  ex_cause_e           ex_cause_q;
  logic [XLen-1:0]     shifted;
  logic [XLen-1:0]     result_d;

  // no read for a faulting load
  assign ram_re_o = valid_i && !ex_valid_i;

  // ------------------
  // wait for RAM data
  // ------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= 1'b0;
      ex_valid_q <= 1'b0;
    end else begin
      valid_q    <= valid_i;
      ex_valid_q <= valid_i && ex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_q       <= lsu_op_i;
    addr_q     <= addr_i;
    trans_id_q <= trans_id_i;
    ex_cause_q <= ex_cause_i;
  end

  // move the addressed lane down to bit 0
  assign shifted = ram_rdata_i >> {addr_q[1:0], 3'b000};

  always_comb begin
    case (op_q)
      LB:      result_d = {{(XLen-8){shifted[7]}}, shifted[7:0]};
      LBU:     result_d = {{(XLen-8){1'b0}}, shifted[7:0]};
      LH:      result_d = {{(XLen-16){shifted[15]}}, shifted[15:0]};
      LHU:     result_d = {{(XLen-16){1'b0}}, shifted[15:0]};
      default: result_d = shifted;
    endcase
    // RAM output is stale on a fault
    if (ex_valid_q) begin
      result_d = '0;
    end
  end

  // ------------------
  // response register
  // ------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_valid_o    <= 1'b0;
      load_ex_valid_o <= 1'b0;
    end else begin
      load_valid_o    <= valid_q;
      load_ex_valid_o <= ex_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    load_result_o   <= result_d;
    load_trans_id_o <= trans_id_q;
    load_ex_cause_o <= ex_cause_q;
    load_ex_tval_o  <= addr_q;
  end

endmodule

/* logic/lsu_pkg.sv */
// ------------------
// shared definitions for the load/store unit
// widths, RAM geometry, operation and
// exception cause encodings
// ------------------

package lsu_pkg;

  // ------------------
  // widths
  // ------------------
  // data and address width
  localparam int unsigned XLen = 32;

  // bytes per data word
  localparam int unsigned BeW = XLen / 8;

  // scoreboard tag carried with each request
  localparam int unsigned TransIdW = 3;

  // ------------------
  // data RAM geometry
  // ------------------
  localparam int unsigned RamWords = 256;

  // word address into the RAM
  localparam int unsigned RamAddrW = 8;

  // bytes reachable in the RAM, any higher address bit is a fault
  localparam int unsigned ByteAddrW = 10;

  // ------------------
  // operations
  // ------------------
  // loads first, then stores
  typedef enum logic [3:0] {
    LB  = 4'd0,
    LBU = 4'd1,
    LH  = 4'd2,
    LHU = 4'd3,
    LW  = 4'd4,
    SB  = 4'd5,
    SH  = 4'd6,
    SW  = 4'd7
  } lsu_op_e;

  // ------------------
  // exception causes
  // ------------------
  // encodings follow the privileged spec mcause values
  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    LD_ACCESS_FAULT    = 4'd5,
    ST_ADDR_MISALIGNED = 4'd6,
    ST_ACCESS_FAULT    = 4'd7
  } ex_cause_e;

endpackage

/* logic/lsu_store_unit.sv */
// ------------------
// store path
// lane placement, RAM write request,
// registered store response
// ------------------

module lsu_store_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          valid_i,
  input  logic [lsu_pkg::XLen-1:0]      addr_i,
  input  logic [lsu_pkg::BeW-1:0]       be_i,
  input  logic [lsu_pkg::XLen-1:0]      wdata_i,
  input  logic [lsu_pkg::TransIdW-1:0]  trans_id_i,
  input  logic                          ex_valid_i,
  input  lsu_pkg::ex_cause_e            ex_cause_i,
  output logic                          ram_we_o,
  output logic [lsu_pkg::BeW-1:0]       ram_be_o,
  output logic [lsu_pkg::XLen-1:0]      ram_wdata_o,
  output logic                          store_valid_o,
  output logic [lsu_pkg::TransIdW-1:0]  store_trans_id_o,
  output logic                          store_ex_valid_o,
  output lsu_pkg::ex_cause_e            store_ex_cause_o,
  output logic [lsu_pkg::XLen-1:0]      store_ex_tval_o
);

  import lsu_pkg::*;

  // byte and half word data sits in the low bits of the operand
  assign ram_wdata_o = wdata_i << {addr_i[1:0], 3'b000};
  assign ram_be_o    = be_i;

  // a faulting store never touches the RAM
  assign ram_we_o = valid_i && !ex_valid_i;

  // ------------------
  // response register
  // ------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_valid_o    <= 1'b0;
      store_ex_valid_o <= 1'b0;
    end else begin
      store_valid_o    <= valid_i;
      store_ex_valid_o <= valid_i && ex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    store_trans_id_o <= trans_id_i;
    store_ex_cause_o <= ex_cause_i;
    store_ex_tval_o  <= addr_i;
  end

endmodule

/* logic/lsu_top.sv */
// ------------------
// load/store unit top level
// request register, load/store steering,
// shared RAM port
// ------------------

module lsu_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // request
  input  logic                          lsu_valid_i,
  input  lsu_pkg::lsu_op_e              lsu_op_i,
  input  logic [lsu_pkg::XLen-1:0]      operand_a_i,
  input  logic [lsu_pkg::XLen-1:0]      operand_b_i,
  input  logic [lsu_pkg::XLen-1:0]      imm_i,
  input  logic [lsu_pkg::TransIdW-1:0]  trans_id_i,
  // load response
  output logic                          load_valid_o,
  output logic [lsu_pkg::TransIdW-1:0]  load_trans_id_o,
  output logic [lsu_pkg::XLen-1:0]      load_result_o,
  output logic                          load_ex_valid_o,
  output lsu_pkg::ex_cause_e            load_ex_cause_o,
  output logic [lsu_pkg::XLen-1:0]      load_ex_tval_o,
  // store response
  output logic                          store_valid_o,
  output logic [lsu_pkg::TransIdW-1:0]  store_trans_id_o,
  output logic                          store_ex_valid_o,
  output lsu_pkg::ex_cause_e            store_ex_cause_o,
  output logic [lsu_pkg::XLen-1:0]      store_ex_tval_o
);

  import lsu_pkg::*;

  // agu results
  logic [XLen-1:0]     agu_addr;
  logic [BeW-1:0]      agu_be;
  logic                agu_is_store;
  logic                agu_ex_valid;
  ex_cause_e           agu_ex_cause;

  // request register
  logic                req_valid_q;
  logic                req_is_store_q;
  logic                req_ex_valid_q;
  lsu_op_e             req_op_q;
  logic [XLen-1:0]     req_addr_q;
  logic [BeW-1:0]      req_be_q;
  logic [XLen-1:0]     req_wdata_q;
  logic [TransIdW-1:0] req_trans_id_q;
  ex_cause_e           req_ex_cause_q;

  logic                st_valid;
  logic                ld_valid;

  // RAM port
  logic                ram_we;
  logic                ram_re;
  logic [BeW-1:0]      ram_be;
  logic [XLen-1:0]     ram_wdata;
  logic [XLen-1:0]     ram_rdata;

  lsu_agu u_agu (
    .lsu_op_i    (lsu_op_i),
    .operand_a_i (operand_a_i),
    .imm_i       (imm_i),
    .addr_o      (agu_addr),
    .be_o        (agu_be),
    .is_store_o  (agu_is_store),
    .ex_valid_o  (agu_ex_valid),
    .ex_cause_o  (agu_ex_cause)
  );

  // ------------------
  // request register
  // ------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q    <= 1'b0;
      req_is_store_q <= 1'b0;
      req_ex_valid_q <= 1'b0;
    end else begin
      req_valid_q    <= lsu_valid_i;
      req_is_store_q <= agu_is_store;
      req_ex_valid_q <= agu_ex_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    req_op_q       <= lsu_op_i;
    req_addr_q     <= agu_addr;
    req_be_q       <= agu_be;
    req_wdata_q    <= operand_b_i;
    req_trans_id_q <= trans_id_i;
    req_ex_cause_q <= agu_ex_cause;
  end

  // one registered request goes to exactly one path
  assign st_valid = req_valid_q && req_is_store_q;
  assign ld_valid = req_valid_q && !req_is_store_q;

  lsu_store_unit u_store_unit (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .valid_i          (st_valid),
    .addr_i           (req_addr_q),
    .be_i             (req_be_q),
    .wdata_i          (req_wdata_q),
    .trans_id_i       (req_trans_id_q),
    .ex_valid_i       (req_ex_valid_q),
    .ex_cause_i       (req_ex_cause_q),
    .ram_we_o         (ram_we),
    .ram_be_o         (ram_be),
    .ram_wdata_o      (ram_wdata),
    .store_valid_o    (store_valid_o),
    .store_trans_id_o (store_trans_id_o),
    .store_ex_valid_o (store_ex_valid_o),
    .store_ex_cause_o (store_ex_cause_o),
    .store_ex_tval_o  (store_ex_tval_o)
  );

  lsu_load_unit u_load_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .valid_i         (ld_valid),
    .lsu_op_i        (req_op_q),
    .addr_i          (req_addr_q),
    .trans_id_i      (req_trans_id_q),
    .ex_valid_i      (req_ex_valid_q),
    .ex_cause_i      (req_ex_cause_q),
    .ram_rdata_i     (ram_rdata),
    .ram_re_o        (ram_re),
    .load_valid_o    (load_valid_o),
    .load_trans_id_o (load_trans_id_o),
    .load_result_o   (load_result_o),
    .load_ex_valid_o (load_ex_valid_o),
    .load_ex_cause_o (load_ex_cause_o),
    .load_ex_tval_o  (load_ex_tval_o)
  );

  // ------------------
  // shared RAM port
  // ------------------
  // read and write never overlap, both come from the same register
  lsu_data_ram u_data_ram (
    .clk_i   (clk_i),
    .req_i   (ram_we || ram_re),
    .we_i    (ram_we),
    .addr_i  (req_addr_q[RamAddrW+1:2]),
    .be_i    (ram_be),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

/* lsu_top.f */
logic/lsu_pkg.sv
logic/lsu_agu.sv
logic/lsu_store_unit.sv
logic/lsu_load_unit.sv
logic/lsu_data_ram.sv
logic/lsu_top.sv
sim/tb_clock_gen.sv
sim/tb_lsu_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_lsu_top -Mdir obj_dir -f lsu_top.f \
  && ./obj_dir/Vtb_lsu_top > sim.log 2>&1

cat sim.log 2>/dev/null

# the log decides pass or fail
grep -q "^No errors$" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

/* sim/tb_clock_gen.sv */
// ------------------
// testbench clock and reset
// 20 ns clock, reset low for 8 cycles
// ------------------

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned half_period = 10;
  localparam int unsigned reset_cycles = 8;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(half_period) clk_o = ~clk_o;
    end
  end

  // release a little after an edge
  initial begin
    rst_no = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

/* sim/tb_lsu_top.sv */
// ------------------
// testbench for the load/store unit
// LFSR stimulus, byte memory model,
// response queues and checks
// ------------------

module tb_lsu_top;

  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  // expected response of one request
  typedef struct packed {
    logic [31:0] due;
    logic [2:0]  id;
    logic        ex;
    logic [3:0]  cause;
    logic [31:0] tval;
    logic [31:0] result;
    logic        check_result;
  } resp_t;

  logic        clk;
  logic        rst_n;

  logic        lsu_valid_i;
  lsu_op_e     lsu_op_i;
  logic [31:0] operand_a_i;
  logic [31:0] operand_b_i;
  logic [31:0] imm_i;
  logic [2:0]  trans_id_i;

  logic        load_valid_o;
  logic [2:0]  load_trans_id_o;
  logic [31:0] load_result_o;
  logic        load_ex_valid_o;
  ex_cause_e   load_ex_cause_o;
  logic [31:0] load_ex_tval_o;
  logic        store_valid_o;
  logic [2:0]  store_trans_id_o;
  logic        store_ex_valid_o;
  ex_cause_e   store_ex_cause_o;
  logic [31:0] store_ex_tval_o;

  logic [31:0] lfsr_state = 32'h3406;
  logic [31:0] cyc = '0;
  logic [2:0]  next_id = '0;
  logic [7:0]  mem_model [1024];
  logic        mem_known [1024];
  resp_t       load_q[$];
  resp_t       store_q[$];

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lsu_top DUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .lsu_valid_i      (lsu_valid_i),
    .lsu_op_i         (lsu_op_i),
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .imm_i            (imm_i),
    .trans_id_i       (trans_id_i),
    .load_valid_o     (load_valid_o),
    .load_trans_id_o  (load_trans_id_o),
    .load_result_o    (load_result_o),
    .load_ex_valid_o  (load_ex_valid_o),
    .load_ex_cause_o  (load_ex_cause_o),
    .load_ex_tval_o   (load_ex_tval_o),
    .store_valid_o    (store_valid_o),
    .store_trans_id_o (store_trans_id_o),
    .store_ex_valid_o (store_ex_valid_o),
    .store_ex_cause_o (store_ex_cause_o),
    .store_ex_tval_o  (store_ex_tval_o)
  );

  // cyc == n right after edge n
  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
  end

  // --------------------
  // random numbers
  // --------------------
  // taps 32, 22, 2, 1
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_next_bit()};
    end
    return value;
  endfunction

  function automatic logic [31:0] rand_addr();
    logic [31:0] value;
    value = rand_bits(10);
    return value & 32'h0000_03ff;
  endfunction

  // sign-extended 12 bit immediate
  function automatic logic [31:0] rand_imm();
    logic [31:0] r;
    r = rand_bits(12);
    return {{20{r[11]}}, r[11:0]};
  endfunction

  // --------------------
  // reference rules
  // --------------------
  function automatic int unsigned op_size(input lsu_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic logic op_is_store(input lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  function automatic logic [31:0] align_addr(input logic [31:0] addr, input int unsigned size);
    return addr & ~(32'(size) - 32'd1);
  endfunction

  // --------------------
  // checks
  // --------------------
  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t", name, actual, expected,
               $time);
      abort_run();
    end
  endtask

  task automatic check_store_port();
    resp_t exp;
    logic  due_now;
    due_now = (store_q.size() != 0) && (store_q[0].due == cyc);
    check_value("store_valid_o", 32'(store_valid_o), 32'(due_now));
    if (due_now) begin
      exp = store_q.pop_front();
      check_value("store_trans_id_o", 32'(store_trans_id_o), 32'(exp.id));
      check_value("store_ex_valid_o", 32'(store_ex_valid_o), 32'(exp.ex));
      if (exp.ex) begin
        check_value("store_ex_cause_o", 32'(store_ex_cause_o), 32'(exp.cause));
        check_value("store_ex_tval_o", store_ex_tval_o, exp.tval);
      end
    end
  endtask

  task automatic check_load_port();
    resp_t exp;
    logic  due_now;
    due_now = (load_q.size() != 0) && (load_q[0].due == cyc);
    check_value("load_valid_o", 32'(load_valid_o), 32'(due_now));
    if (due_now) begin
      exp = load_q.pop_front();
      check_value("load_trans_id_o", 32'(load_trans_id_o), 32'(exp.id));
      check_value("load_ex_valid_o", 32'(load_ex_valid_o), 32'(exp.ex));
      if (exp.ex) begin
        check_value("load_ex_cause_o", 32'(load_ex_cause_o), 32'(exp.cause));
        check_value("load_ex_tval_o", load_ex_tval_o, exp.tval);
      end
      // never-written bytes are not compared
      if (exp.ex || exp.check_result) begin
        check_value("load_result_o", load_result_o, exp.result);
      end
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_store_port();
      check_load_port();
    end
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic idle_cycle();
    lsu_valid_i = 1'b0;
    @(posedge clk);
    #2;
  endtask

  task automatic issue_request(input lsu_op_e op, input logic [31:0] base,
                               input logic [31:0] data, input logic [31:0] imm);
    logic [31:0] addr;
    logic [31:0] word;
    logic [9:0]  idx;
    int unsigned size;
    logic        misaligned;
    logic        out_of_range;
    logic        known;
    resp_t       resp;
    addr         = base + imm;
    size         = op_size(op);
    misaligned   = ((size == 2) && addr[0]) || ((size == 4) && (addr[1:0] != 2'b00));
    out_of_range = |addr[31:10];
    resp.id           = next_id;
    resp.ex           = misaligned || out_of_range;
    resp.tval         = addr;
    resp.result       = '0;
    resp.check_result = 1'b1;
    if (op_is_store(op)) begin
      resp.due   = cyc + 32'd2;
      resp.cause = out_of_range ? ST_ACCESS_FAULT : ST_ADDR_MISALIGNED;
      if (!resp.ex) begin
        for (int unsigned i = 0; i < size; i++) begin
          idx            = addr[9:0] + 10'(i);
          mem_model[idx] = data[8*i +: 8];
          mem_known[idx] = 1'b1;
        end
      end
      store_q.push_back(resp);
    end else begin
      resp.due   = cyc + 32'd3;
      resp.cause = out_of_range ? LD_ACCESS_FAULT : LD_ADDR_MISALIGNED;
      if (!resp.ex) begin
        word  = '0;
        known = 1'b1;
        for (int unsigned i = 0; i < size; i++) begin
          idx             = addr[9:0] + 10'(i);
          word[8*i +: 8]  = mem_model[idx];
          known           = known & mem_known[idx];
        end
        case (op)
          LB:      resp.result = {{24{word[7]}}, word[7:0]};
          LH:      resp.result = {{16{word[15]}}, word[15:0]};
          default: resp.result = word;
        endcase
        resp.check_result = known;
      end
      load_q.push_back(resp);
    end
    lsu_valid_i = 1'b1;
    lsu_op_i    = op;
    operand_a_i = base;
    operand_b_i = data;
    imm_i       = imm;
    trans_id_i  = next_id;
    next_id     = next_id + 3'd1;
    @(posedge clk);
    #2;
    lsu_valid_i = 1'b0;
  endtask

  // base chosen so that base plus a random immediate hits addr
  task automatic issue_at(input lsu_op_e op, input logic [31:0] addr,
                          input logic [31:0] data);
    logic [31:0] imm;
    imm = rand_imm();
    issue_request(op, addr - imm, data, imm);
  endtask

  initial begin : stimulus
    int unsigned timeout;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] hi;
    lsu_op_e     st_op;
    lsu_op_e     ld_op;
    lsu_op_e     op;
    lsu_valid_i = 1'b0;
    lsu_op_i    = LB;
    operand_a_i = '0;
    operand_b_i = '0;
    imm_i       = '0;
    trans_id_i  = '0;
    for (int i = 0; i < 1024; i++) begin
      mem_known[i] = 1'b0;
    end

    timeout = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      timeout++;
      if (timeout > 50) begin
        $display("reset was never released");
        abort_run();
      end
    end
    #2;

    // quiet outputs after reset
    repeat (6) idle_cycle();

    // store and same-width load, then loads of every width
    for (int n = 0; n < 40; n++) begin
      r = rand_bits(3);
      case (r[1:0])
        2'd0: begin
          st_op = SB;
          ld_op = r[2] ? LBU : LB;
        end
        2'd1: begin
          st_op = SH;
          ld_op = r[2] ? LHU : LH;
        end
        default: begin
          st_op = SW;
          ld_op = LW;
        end
      endcase
      addr = align_addr(rand_addr(), op_size(st_op));
      issue_at(st_op, addr, rand_bits(32));
      issue_at(ld_op, addr, '0);
      issue_at(LB, addr, '0);
      issue_at(LBU, addr, '0);
      issue_at(LH, align_addr(addr, 2), '0);
      issue_at(LHU, align_addr(addr, 2), '0);
      issue_at(LW, align_addr(addr, 4), '0);
    end

    // back-to-back random stream
    for (int n = 0; n < 200; n++) begin
      r    = rand_bits(3);
      op   = lsu_op_e'(r[3:0]);
      addr = align_addr(rand_addr(), op_size(op));
      issue_at(op, addr, rand_bits(32));
    end

    // misaligned half-word and word accesses
    for (int n = 0; n < 30; n++) begin
      r = rand_bits(3);
      case (r[2:0])
        3'd0:    op = LH;
        3'd1:    op = LHU;
        3'd2:    op = LW;
        3'd3:    op = SH;
        default: op = SW;
      endcase
      word = rand_addr() & 32'h0000_03fc;
      issue_at(SW, word, rand_bits(32));
      r = rand_bits(2);
      if (op_size(op) == 2) begin
        r[0] = 1'b1;
      end else if (r[1:0] == 2'b00) begin
        r[0] = 1'b1;
      end
      issue_at(op, word + {30'd0, r[1:0]}, rand_bits(32));
      issue_at(LW, word, '0);
    end

    // out-of-range accesses, some also misaligned
    for (int n = 0; n < 30; n++) begin
      r    = rand_bits(3);
      op   = lsu_op_e'(r[3:0]);
      addr = rand_addr();
      hi   = rand_bits(22);
      if (hi == 32'd0) begin
        hi = 32'd1;
      end
      word = addr & 32'h0000_03fc;
      issue_at(SW, word, rand_bits(32));
      issue_at(op, {hi[21:0], addr[9:0]}, rand_bits(32));
      issue_at(LW, word, '0);
    end

    // let the pipeline empty
    timeout = 0;
    while ((load_q.size() != 0) || (store_q.size() != 0)) begin
      idle_cycle();
      timeout++;
      if (timeout > 20) begin
        $display("responses still outstanding after the drain timeout");
        abort_run();
      end
    end

    // no stray responses once idle
    repeat (4) idle_cycle();

    $display("No errors");
    $finish;
  end

endmodule
